/* hw/alu_pkg.sv */
package alu_pkg;

  // basic datapath widths of the rv32i execute unit
  typedef logic [31:0] word;

  // rv32i only looks at the low five bits of a shift amount
  typedef logic [4:0] shift_t;

  // one extra bit on top of a word so that compares can read the carry
  typedef logic [32:0] adder_in_t;

  // selects what the setup stage puts into the low word of the shifter
  typedef enum logic [1:0] {
    ALU_BITWISE_AND  = 2'b00,
    ALU_BITWISE_OR   = 2'b01,
    ALU_BITWISE_XOR  = 2'b10,
    ALU_BITWISE_PASS = 2'b11
  } alu_bitwise_e;

  // final result mux in the shift/add stage
  typedef enum logic {
    ALU_OUT_ADDER = 1'b0,
    ALU_OUT_SHIFT = 1'b1
  } alu_out_e;

  // fields every execute unit passes through to commit untouched
  typedef struct packed {
    word        pc;
    word        pc_increment;
    word        rs1;
    word        rs2;
    word        immediate;
    logic [4:0] rd;
  } exec_common_t;

  // decoded alu op as it arrives from issue
  typedef struct packed {
    exec_common_t common;
    alu_bitwise_e bitwise_select;
    alu_out_e     out_select;
    logic         is_immediate;
    logic         negate;
    logic         flip_signs;
    logic         sign_extend;
    logic         compare;
    logic         pc_relative;
    logic         illegal;
  } alu_data_t;

  // record handed to the commit unit
  typedef struct packed {
    exec_common_t common;
    word          result;
    word          next_pc;
    logic         jump;
    logic         trap;
    logic         writeback;
  } commit_data_t;

  // pipeline register between operand setup and shift/add
  typedef struct packed {
    alu_data_t ctrl;
    word       shift_lo;
    word       shift_hi;
    shift_t    shift_count;
    adder_in_t adder_a;
    adder_in_t adder_b;
  } alu_stage_t;

endpackage

/* hw/alu_operand_setup.sv */
module alu_operand_setup
  import alu_pkg::*;
(
  input  logic       clk_core,
  input  logic       rst_core_n,
  input  logic       stall_i,
  input  logic       flush_req_i,
  input  logic       valid_i,
  input  alu_data_t  alu_data_i,
  output logic       valid_o,
  output alu_stage_t stage_o
);

  word        operand_a;
  word        operand_b;
  logic       b_nonzero;
  logic       count_nonzero;
  logic       shift_left;
  adder_in_t  operand_a_ext;
  adder_in_t  operand_b_neg;
  alu_stage_t stage_d;

  // operand a is always rs1, b comes from the immediate for the i-type forms
  assign operand_a = alu_data_i.common.rs1;
  assign operand_b = alu_data_i.is_immediate ? alu_data_i.common.immediate
                                             : alu_data_i.common.rs2;

  // the unsigned compare needs the full word, the shifter only the low five bits
  assign b_nonzero     = operand_b != '0;
  assign count_nonzero = operand_b[4:0] != '0;

  // sll by n becomes a right shift of {a, 0} by 32 - n
  // a zero count stays a plain right shift by zero since -0 is 0
  assign shift_left = alu_data_i.negate & count_nonzero;

  // sign extension to 33 bits keeps adder overflow out of the carry bit
  assign operand_a_ext = {operand_a[31], operand_a};
  assign operand_b_neg = alu_data_i.negate ? -{operand_b[31], operand_b}
                                           : {operand_b[31], operand_b};

  always_comb begin
    stage_d.ctrl = alu_data_i;

    // bitwise ops leave their result in the low word and shift it by zero
    case (alu_data_i.bitwise_select)
      ALU_BITWISE_AND: stage_d.shift_lo = operand_a & operand_b;
      ALU_BITWISE_OR:  stage_d.shift_lo = operand_a | operand_b;
      ALU_BITWISE_XOR: stage_d.shift_lo = operand_a ^ operand_b;
      default:         stage_d.shift_lo = shift_left ? '0 : operand_a;
    endcase

    // upper word holds the operand for sll, otherwise the srl/sra fill bits
    if (shift_left) begin
      stage_d.shift_hi = operand_a;
    end else begin
      stage_d.shift_hi = {32{alu_data_i.sign_extend & operand_a[31]}};
    end

    // negated count already equals 32 - n in five bits for sll
    if (alu_data_i.bitwise_select == ALU_BITWISE_PASS) begin
      stage_d.shift_count = operand_b_neg[4:0];
    end else begin
      stage_d.shift_count = '0;
    end

    stage_d.adder_a = operand_a_ext;
    stage_d.adder_b = operand_b_neg;

    // compares run as a - b and read bit 32 of the sum
    if (alu_data_i.compare) begin
      if (alu_data_i.flip_signs) begin
        // signed values map to offset binary so an unsigned test works
        stage_d.adder_a[32] = ~operand_a_ext[32];
        stage_d.adder_b[32] = ~operand_b_neg[32];
      end else begin
        // +a plus -b, and -b is only negative when b was nonzero
        stage_d.adder_a[32] = 1'b0;
        stage_d.adder_b[32] = b_nonzero;
      end
    end

    // auipc adds the immediate to the pc, bit 32 is never looked at
    if (alu_data_i.pc_relative) begin
      stage_d.adder_a = {1'b0, alu_data_i.common.pc};
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o <= 1'b0;
    end else if (flush_req_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!stall_i) begin
      stage_o <= stage_d;
    end
  end

  // an unknown select would pick an arbitrary bitwise result for shift/add
  assert property (@(posedge clk_core) disable iff (!rst_core_n)
    valid_i |-> !$isunknown(alu_data_i.bitwise_select));

endmodule

/* hw/alu_shift_add.sv */
module alu_shift_add
  import alu_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  logic         stall_i,
  input  logic         flush_req_i,
  input  logic         valid_i,
  input  alu_stage_t   stage_i,
  output logic         valid_o,
  output commit_data_t commit_o
);

  word          shift_q;
  logic [32:0]  adder_sum;
  word          adder_q;
  word          alu_q;
  commit_data_t commit_d;

  // one right shifter covers srl, sra and sll
  // srl shifts {0, x}, sra shifts {sign, x} and sll shifts {x, 0} by 32 - n
  // only the low word of the 64-bit result is kept
  assign shift_q = word'({stage_i.shift_hi, stage_i.shift_lo} >> stage_i.shift_count);

  // 33-bit sum, bit 32 is the compare outcome when operands were prepared for it
  assign adder_sum = stage_i.adder_a + stage_i.adder_b;

  always_comb begin
    // slt and sltu give 1 when a < b, zero extended to a full word
    if (stage_i.ctrl.compare) begin
      adder_q = {31'b0, adder_sum[32]};
    end else begin
      adder_q = adder_sum[31:0];
    end

    case (stage_i.ctrl.out_select)
      ALU_OUT_SHIFT: alu_q = shift_q;
      default:       alu_q = adder_q;
    endcase
  end

  // alu ops always write rd and fall through to the next instruction
  always_comb begin
    commit_d.common    = stage_i.ctrl.common;
    commit_d.result    = alu_q;
    commit_d.next_pc   = stage_i.ctrl.common.pc_increment;
    commit_d.jump      = 1'b0;
    commit_d.trap      = stage_i.ctrl.illegal;
    commit_d.writeback = 1'b1;
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o <= 1'b0;
    end else if (flush_req_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!stall_i) begin
      commit_o <= commit_d;
    end
  end

  // setup forwards out_select untouched, so an unknown here came from issue
  assert property (@(posedge clk_core) disable iff (!rst_core_n)
    valid_i |-> !$isunknown(stage_i.ctrl.out_select));

endmodule

/* hw/skid_buffer.sv */
module skid_buffer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_core,
  input  logic     rst_core_n,
  input  logic     flush_req_i,
  input  logic     valid_i,
  input  logic     ready_i,
  input  payload_t data_i,
  output logic     stall_o,
  output logic     valid_o,
  output payload_t data_o
);

  logic     skid_valid;
  payload_t skid_data;
  logic     main_free;
  logic     accept;

  // main slot empties or moves on this edge
  assign main_free = !valid_o || ready_i;

  // upstream is frozen while the skid slot holds an item, so its valid is stale then
  assign accept = valid_i && !skid_valid;

  // stall follows the skid slot and nothing else
  assign stall_o = skid_valid;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (flush_req_i) begin
      valid_o    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // the skid entry is older, so it goes to the main slot first
      if (skid_valid) begin
        valid_o    <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        valid_o <= accept;
      end
    end else if (accept) begin
      // main slot held by back-pressure, park the new item
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_core) begin
    if (main_free) begin
      if (skid_valid) begin
        data_o <= skid_data;
      end else begin
        data_o <= data_i;
      end
    end
    if (!main_free && accept) begin
      skid_data <= data_i;
    end
  end

  // the consumer may sample a held record on any later cycle
  assert property (@(posedge clk_core) disable iff (!rst_core_n)
    valid_o && !ready_i && !flush_req_i |=> valid_o && $stable(data_o));

endmodule

/* hw/alu_stage.sv */
module alu_stage
  import alu_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  logic         flush_req_i,
  output logic         flush_ack_o,
  input  alu_data_t    alu_data_i,
  input  logic         valid_i,
  output logic         ready_o,
  output commit_data_t commit_data_o,
  output logic         valid_o,
  input  logic         ready_i
);

  logic         stall;
  logic         setup_valid;
  alu_stage_t   setup_stage;
  logic         shift_add_valid;
  commit_data_t shift_add_commit;

  // a full skid slot freezes the whole pipe and closes the input
  assign ready_o = !stall;

  // operand selection, negation and bitwise ops
  alu_operand_setup u_setup (
    .clk_core    (clk_core),
    .rst_core_n  (rst_core_n),
    .stall_i     (stall),
    .flush_req_i (flush_req_i),
    .valid_i     (valid_i),
    .alu_data_i  (alu_data_i),
    .valid_o     (setup_valid),
    .stage_o     (setup_stage)
  );

  // shifter, adder and compare, builds the commit record
  alu_shift_add u_shift_add (
    .clk_core    (clk_core),
    .rst_core_n  (rst_core_n),
    .stall_i     (stall),
    .flush_req_i (flush_req_i),
    .valid_i     (setup_valid),
    .stage_i     (setup_stage),
    .valid_o     (shift_add_valid),
    .commit_o    (shift_add_commit)
  );

  skid_buffer #(
    .payload_t (commit_data_t)
  ) u_out_buf (
    .clk_core    (clk_core),
    .rst_core_n  (rst_core_n),
    .flush_req_i (flush_req_i),
    .valid_i     (shift_add_valid),
    .ready_i     (ready_i),
    .data_i      (shift_add_commit),
    .stall_o     (stall),
    .valid_o     (valid_o),
    .data_o      (commit_data_o)
  );

  // all valid bits drop on the request edge, so the ack follows one cycle later
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      flush_ack_o <= 1'b0;
    end else begin
      flush_ack_o <= flush_req_i;
    end
  end

endmodule

/* bench/alu_model.svh */
// rv32i result of the op that the control bits of an alu_data_t describe
// the bits are read as an op name and the result comes from the isa rule for that op
function automatic word expected_result(alu_data_t d);
  word a;
  word b;
  a = d.common.rs1;
  b = d.is_immediate ? d.common.immediate : d.common.rs2;
  // auipc adds the upper immediate to the pc of the instruction
  if (d.pc_relative) begin
    return d.common.pc + d.common.immediate;
  end
  // slt and slti compare as signed, sltu and sltiu as unsigned
  if (d.compare) begin
    if (d.flip_signs) begin
      return {31'b0, $signed(a) < $signed(b)};
    end
    return {31'b0, a < b};
  end
  if (d.out_select == ALU_OUT_ADDER) begin
    return d.negate ? a - b : a + b;
  end
  case (d.bitwise_select)
    ALU_BITWISE_AND: return a & b;
    ALU_BITWISE_OR:  return a | b;
    ALU_BITWISE_XOR: return a ^ b;
    default: begin
      // the isa takes the shift amount from the low five bits only
      if (d.negate) begin
        return a << b[4:0];
      end else if (d.sign_extend) begin
        return word'($signed(a) >>> b[4:0]);
      end
      return a >> b[4:0];
    end
  endcase
endfunction

// every alu op writes rd, never jumps and falls through to pc + 4
function automatic commit_data_t expected_commit(alu_data_t d);
  commit_data_t c;
  c.common    = d.common;
  c.result    = expected_result(d);
  c.next_pc   = d.common.pc_increment;
  c.jump      = 1'b0;
  c.trap      = d.illegal;
  c.writeback = 1'b1;
  return c;
endfunction

/* bench/alu_stage_tb.sv */
module alu_stage_tb;
  import alu_pkg::*;

  `include "alu_model.svh"

  typedef enum int {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL,
    OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_AUIPC
  } op_e;

  // op count of each test, the run limit allows 20 cycles per op
  localparam int ARITH_OPS = 11;
  localparam int SHIFT_OPS = 12;
  localparam int CMP_OPS = 10;
  localparam int AUIPC_OPS = 3;
  localparam int RAND_OPS = 40;
  localparam int FLUSH_OPS = 6;
  localparam int TOTAL_OPS = ARITH_OPS + SHIFT_OPS + CMP_OPS + AUIPC_OPS + RAND_OPS + FLUSH_OPS;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_OPS + 200;

  logic         clk_core;
  logic         rst_core_n;
  logic         flush_req_i;
  logic         flush_ack_o;
  alu_data_t    alu_data_i;
  logic         valid_i;
  logic         ready_o;
  commit_data_t commit_data_o;
  logic         valid_o;
  logic         ready_i;

  commit_data_t exp_q[$];
  commit_data_t held_data;
  logic         hold_pending = 1'b0;
  integer       seed;
  word          pc_next;
  int           errors = 0;
  int           checks = 0;
  int           cycles = 0;

  alu_stage u_alu_stage (.*);

  initial begin
    clk_core = 1'b0;
    forever #5 clk_core = ~clk_core;
  end

  task automatic check_value(input string name, input logic [164:0] got,
                             input logic [164:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // compares one output transfer with the oldest expected record
  task automatic check_record();
    commit_data_t exp;
    if (exp_q.size() == 0) begin
      errors++;
      $display("a record left the DUT with none expected at time %0t", $time);
    end else begin
      exp = exp_q.pop_front();
      check_value("commit_data_o.common", 165'(commit_data_o.common), 165'(exp.common));
      check_value("commit_data_o.result", 165'(commit_data_o.result), 165'(exp.result));
      check_value("commit_data_o.next_pc", 165'(commit_data_o.next_pc), 165'(exp.next_pc));
      check_value("commit_data_o.jump", 165'(commit_data_o.jump), 165'(exp.jump));
      check_value("commit_data_o.trap", 165'(commit_data_o.trap), 165'(exp.trap));
      check_value("commit_data_o.writeback", 165'(commit_data_o.writeback), 165'(exp.writeback));
    end
  endtask

  // values read here are the ones from before the edge, so they are settled
  always @(posedge clk_core) begin
    if (rst_core_n) begin
      // a record held by ready_i low has to stay put until it is taken
      if (hold_pending && (!valid_o || commit_data_o !== held_data)) begin
        errors++;
        $display("commit_data_o changed while ready_i held it at time %0t", $time);
      end
      hold_pending = valid_o && !ready_i && !flush_req_i;
      held_data    = commit_data_o;
      // a flush drops everything in flight, so nothing is expected any more
      if (flush_req_i) begin
        exp_q.delete();
      end else if (valid_o && ready_i) begin
        check_record();
      end
    end
  end

  always @(posedge clk_core) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles with ops still pending", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // builds the decoded form of an rv32i alu op
  function automatic alu_data_t make_op(op_e op, word a, word b, word imm, logic use_imm);
    alu_data_t d;
    d                  = '0;
    d.common.rs1       = a;
    d.common.rs2       = b;
    d.common.immediate = imm;
    d.is_immediate     = use_imm || op == OP_AUIPC;
    d.out_select       = op inside {OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA} ?
                         ALU_OUT_SHIFT : ALU_OUT_ADDER;
    d.negate           = op inside {OP_SUB, OP_SLL, OP_SLT, OP_SLTU};
    d.compare          = op inside {OP_SLT, OP_SLTU};
    d.flip_signs       = op == OP_SLT;
    d.sign_extend      = op == OP_SRA;
    d.pc_relative      = op == OP_AUIPC;
    case (op)
      OP_AND:  d.bitwise_select = ALU_BITWISE_AND;
      OP_OR:   d.bitwise_select = ALU_BITWISE_OR;
      OP_XOR:  d.bitwise_select = ALU_BITWISE_XOR;
      default: d.bitwise_select = ALU_BITWISE_PASS;
    endcase
    return d;
  endfunction

  function automatic alu_data_t random_op();
    word       a;
    word       b;
    word       imm;
    word       pick;
    alu_data_t d;
    a    = $random(seed);
    b    = $random(seed);
    imm  = $random(seed);
    pick = $random(seed);
    d    = make_op(op_e'(pick % 32'd11), a, b, imm, pick[8]);
    // roughly one op in four comes in as illegal
    d.illegal = pick[9] & pick[10];
    return d;
  endfunction

  // called on a falling edge, holds the op until ready_o lets it in
  task automatic send_op(input alu_data_t op);
    alu_data_t d;
    d                     = op;
    d.common.pc           = pc_next;
    d.common.pc_increment = pc_next + 32'd4;
    d.common.rd           = pc_next[6:2];
    pc_next               = pc_next + 32'd4;
    alu_data_i            = d;
    valid_i               = 1'b1;
    // ready_o only moves on rising edges, so the falling edge value holds
    while (!ready_o) @(negedge clk_core);
    exp_q.push_back(expected_commit(d));
    @(negedge clk_core);
    valid_i = 1'b0;
  endtask

  task automatic drain();
    ready_i = 1'b1;
    while (exp_q.size() != 0) @(negedge clk_core);
  endtask

  task automatic end_test(input string name, input int start);
    $display("%s finished with %0d errors", name, errors - start);
  endtask

  task automatic arith_test();
    int start;
    start = errors;
    send_op(make_op(OP_ADD, 32'd7, 32'd5, 32'd0, 1'b0));
    // signed overflow and carry out both wrap to 32 bits
    send_op(make_op(OP_ADD, 32'h7fff_ffff, 32'd1, 32'd0, 1'b0));
    send_op(make_op(OP_ADD, 32'hffff_ffff, 32'd2, 32'd0, 1'b0));
    send_op(make_op(OP_ADD, 32'd100, 32'd0, 32'hffff_f800, 1'b1));
    send_op(make_op(OP_SUB, 32'd3, 32'd5, 32'd0, 1'b0));
    send_op(make_op(OP_SUB, 32'h8000_0000, 32'd1, 32'd0, 1'b0));
    send_op(make_op(OP_AND, 32'hf0f0_1234, 32'h0ff0_ffff, 32'd0, 1'b0));
    send_op(make_op(OP_AND, 32'hdead_beef, 32'd0, 32'h0000_0ff0, 1'b1));
    send_op(make_op(OP_OR, 32'h0000_00f0, 32'd0, 32'h0000_070f, 1'b1));
    send_op(make_op(OP_XOR, 32'h1234_5678, 32'hffff_0000, 32'd0, 1'b0));
    send_op(make_op(OP_XOR, 32'h1234_5678, 32'd0, 32'hffff_ffff, 1'b1));
    drain();
    end_test("arith_logic", start);
  endtask

  task automatic shift_test();
    int start;
    start = errors;
    // sll by zero has to give the operand back unchanged
    send_op(make_op(OP_SLL, 32'h8000_0001, 32'd0, 32'd0, 1'b0));
    send_op(make_op(OP_SLL, 32'h8000_0001, 32'd1, 32'd0, 1'b0));
    send_op(make_op(OP_SLL, 32'h8000_0001, 32'd31, 32'd0, 1'b0));
    send_op(make_op(OP_SLL, 32'h0000_0003, 32'h0000_0021, 32'd0, 1'b0));
    send_op(make_op(OP_SLL, 32'h1234_5678, 32'd0, 32'd4, 1'b1));
    send_op(make_op(OP_SRL, 32'h8000_0000, 32'd1, 32'd0, 1'b0));
    send_op(make_op(OP_SRL, 32'h8000_0000, 32'd31, 32'd0, 1'b0));
    send_op(make_op(OP_SRL, 32'h8765_4321, 32'hffff_ffe0, 32'd0, 1'b0));
    send_op(make_op(OP_SRA, 32'h8000_0000, 32'd1, 32'd0, 1'b0));
    // srai carries bit 10 of the immediate, only the low five bits count
    send_op(make_op(OP_SRA, 32'h8000_0000, 32'd0, 32'h0000_041f, 1'b1));
    send_op(make_op(OP_SRA, 32'h4000_0000, 32'd2, 32'd0, 1'b0));
    send_op(make_op(OP_SRA, 32'hf000_000f, 32'hffff_ffe4, 32'd0, 1'b0));
    drain();
    end_test("shift", start);
  endtask

  task automatic compare_test();
    int start;
    start = errors;
    send_op(make_op(OP_SLT, 32'd5, 32'd5, 32'd0, 1'b0));
    send_op(make_op(OP_SLT, 32'h8000_0000, 32'h7fff_ffff, 32'd0, 1'b0));
    send_op(make_op(OP_SLT, 32'h7fff_ffff, 32'h8000_0000, 32'd0, 1'b0));
    send_op(make_op(OP_SLT, 32'hffff_ffff, 32'd1, 32'd0, 1'b0));
    send_op(make_op(OP_SLT, 32'd1, 32'd0, 32'hffff_f800, 1'b1));
    send_op(make_op(OP_SLTU, 32'd5, 32'd5, 32'd0, 1'b0));
    send_op(make_op(OP_SLTU, 32'h8000_0000, 32'h7fff_ffff, 32'd0, 1'b0));
    send_op(make_op(OP_SLTU, 32'h7fff_ffff, 32'h8000_0000, 32'd0, 1'b0));
    // sltu against zero is the case where negated b has no borrow
    send_op(make_op(OP_SLTU, 32'd0, 32'd0, 32'd1, 1'b1));
    send_op(make_op(OP_SLTU, 32'd5, 32'd0, 32'd0, 1'b0));
    drain();
    end_test("compare", start);
  endtask

  task automatic auipc_test();
    int        start;
    alu_data_t bad;
    start = errors;
    send_op(make_op(OP_AUIPC, 32'd0, 32'd0, 32'h1234_5000, 1'b1));
    send_op(make_op(OP_AUIPC, 32'd0, 32'd0, 32'hffff_f000, 1'b1));
    bad         = make_op(OP_ADD, 32'd9, 32'd4, 32'd0, 1'b0);
    bad.illegal = 1'b1;
    send_op(bad);
    drain();
    end_test("auipc_illegal", start);
  endtask

  task automatic back_pressure_test();
    int  start;
    bit  sending;
    word ready_bits;
    start   = errors;
    sending = 1'b1;
    fork
      begin
        repeat (RAND_OPS) send_op(random_op());
        sending = 1'b0;
      end
      // the consumer takes records on random cycles only
      while (sending) begin
        ready_bits = $random(seed);
        ready_i    = ready_bits[0];
        @(negedge clk_core);
      end
    join
    drain();
    end_test("back_pressure", start);
  endtask

  task automatic flush_test();
    int start;
    start   = errors;
    ready_i = 1'b0;
    // four ops fill main slot, skid slot and both stage registers
    repeat (4) send_op(random_op());
    repeat (3) @(negedge clk_core);
    check_value("ready_o", 165'(ready_o), 165'(1'b0));
    flush_req_i = 1'b1;
    @(negedge clk_core);
    flush_req_i = 1'b0;
    check_value("flush_ack_o", 165'(flush_ack_o), 165'(1'b1));
    check_value("valid_o", 165'(valid_o), 165'(1'b0));
    check_value("ready_o", 165'(ready_o), 165'(1'b1));
    @(negedge clk_core);
    check_value("flush_ack_o", 165'(flush_ack_o), 165'(1'b0));
    ready_i = 1'b1;
    send_op(make_op(OP_SUB, 32'd10, 32'd3, 32'd0, 1'b0));
    send_op(make_op(OP_SLL, 32'h0000_0001, 32'd0, 32'd8, 1'b1));
    drain();
    end_test("flush", start);
  endtask

  initial begin
    seed        = 32'ha993_b069;
    pc_next     = 32'h0000_1000;
    rst_core_n  = 1'b0;
    flush_req_i = 1'b0;
    valid_i     = 1'b0;
    ready_i     = 1'b1;
    alu_data_i  = '0;
    repeat (2) @(posedge clk_core);
    @(negedge clk_core);
    rst_core_n = 1'b1;
    check_value("valid_o", 165'(valid_o), 165'(1'b0));
    check_value("ready_o", 165'(ready_o), 165'(1'b1));
    check_value("flush_ack_o", 165'(flush_ack_o), 165'(1'b0));
    arith_test();
    shift_test();
    compare_test();
    auipc_test();
    back_pressure_test();
    flush_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+bench
hw/alu_pkg.sv
hw/alu_operand_setup.sv
hw/alu_shift_add.sv
hw/skid_buffer.sv
hw/alu_stage.sv
bench/alu_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the alu stage testbench with verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module alu_stage_tb -o alu_stage_sim
./obj_dir/alu_stage_sim | tee sim.log
grep -q "ALL CHECKS PASSED" sim.log
echo "simulation passed"
